//--- defs_pkg.sv
/*
 * Shared sizes, response and burst codes, and FSM state types for the
 * AXI4 SSRAM controller. Imported by every design unit.
 */
`default_nettype none

package defs_pkg;

  // AXI4 port sizes
  localparam int AXI_ID_W   = 2;
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_LEN_W  = 8;
  localparam int DATA_W     = 64;
  localparam int STRB_W     = DATA_W / 8;

  // Memory geometry
  localparam int MEM_AW    = 10;
  localparam int MEM_DEPTH = 1 << MEM_AW;
  // Byte offset bits below the word address
  localparam int WORD_LSB  = $clog2(STRB_W);

  // Response codes on B and R
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Burst types, WRAP is handled like INCR
  localparam logic [1:0] BURST_FIXED = 2'b00;
  localparam logic [1:0] BURST_INCR  = 2'b01;

  typedef enum logic [1:0] {
    W_IDLE,
    W_DATA,
    W_RESP
  } wr_state_e;

  typedef enum logic [1:0] {
    R_IDLE,
    R_ISSUE,
    R_WAIT,
    R_SEND
  } rd_state_e;

endpackage

`default_nettype wire

//--- ssram_if.sv
/*
 * Request bundle from one engine to the SSRAM arbiter.
 * The engine drives the request fields, the arbiter returns the grant.
 */
`timescale 1ns/10ps
`default_nettype none

interface ssram_if;
  import defs_pkg::*;

  logic              req;
  logic              we;
  logic [MEM_AW-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] be;
  logic              gnt;

  modport engine  (output req, we, addr, wdata, be, input gnt);
  modport arbiter (input req, we, addr, wdata, be, output gnt);

endinterface

`default_nettype wire

//--- axi_wr_engine.sv
/*
 * AXI4 write engine. Takes one AW burst at a time, turns each granted
 * W beat into a masked SSRAM write and returns a single B response.
 */
`timescale 1ns/10ps
`default_nettype none

module axi_wr_engine (
  input  logic                            clk,
  input  logic                            i_reset,
  input  logic [defs_pkg::AXI_ID_W-1:0]   i_axi_awid,
  input  logic [defs_pkg::AXI_ADDR_W-1:0] i_axi_awaddr,
  input  logic [defs_pkg::AXI_LEN_W-1:0]  i_axi_awlen,
  input  logic [1:0]                      i_axi_awburst,
  input  logic                            i_axi_awvalid,
  output logic                            o_axi_awready,
  input  logic [defs_pkg::DATA_W-1:0]     i_axi_wdata,
  input  logic [defs_pkg::STRB_W-1:0]     i_axi_wstrb,
  input  logic                            i_axi_wlast,
  input  logic                            i_axi_wvalid,
  output logic                            o_axi_wready,
  output logic [defs_pkg::AXI_ID_W-1:0]   o_axi_bid,
  output logic [1:0]                      o_axi_bresp,
  output logic                            o_axi_bvalid,
  input  logic                            i_axi_bready,
  ssram_if.engine                         o_mem
);
  import defs_pkg::*;

  wr_state_e            state;
  logic [AXI_ID_W-1:0]  w_id;
  logic [MEM_AW-1:0]    w_addr;
  logic [AXI_LEN_W-1:0] w_len;
  logic [AXI_LEN_W-1:0] w_cnt;
  logic                 w_incr;
  logic                 w_oor;
  logic                 aw_hs;
  logic                 w_beat;
  logic                 w_end;

  assign aw_hs  = o_axi_awready && i_axi_awvalid;
  assign w_beat = o_axi_wready && i_axi_wvalid;
  // Burst ends on wlast, or on the beat count if the master omits it
  assign w_end  = i_axi_wlast || (w_cnt == w_len);

  assign o_axi_awready = (state == W_IDLE);
  // Out-of-range beats are taken without touching the memory
  assign o_axi_wready  = (state == W_DATA) && (w_oor || o_mem.gnt);
  assign o_axi_bvalid  = (state == W_RESP);
  assign o_axi_bid     = w_id;
  assign o_axi_bresp   = w_oor ? RESP_SLVERR : RESP_OKAY;

  assign o_mem.req   = (state == W_DATA) && i_axi_wvalid && !w_oor;
  assign o_mem.we    = 1'b1;
  assign o_mem.addr  = w_addr;
  assign o_mem.wdata = i_axi_wdata;
  assign o_mem.be    = i_axi_wstrb;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      state <= W_IDLE;
    end else begin
      case (state)
        W_IDLE: if (aw_hs) state <= W_DATA;
        W_DATA: if (w_beat && w_end) state <= W_RESP;
        W_RESP: if (i_axi_bready) state <= W_IDLE;
        default: state <= W_IDLE;
      endcase
    end
  end

  // Burst context and address counter
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      w_id   <= i_axi_awid;
      w_addr <= i_axi_awaddr[MEM_AW+WORD_LSB-1:WORD_LSB];
      w_len  <= i_axi_awlen;
      w_cnt  <= '0;
      w_incr <= (i_axi_awburst != BURST_FIXED);
      w_oor  <= |i_axi_awaddr[AXI_ADDR_W-1:MEM_AW+WORD_LSB];
    end else if (w_beat) begin
      w_cnt <= w_cnt + 1'b1;
      if (w_incr) begin
        w_addr <= w_addr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- axi_rd_engine.sv
/*
 * AXI4 read engine. Takes one AR burst at a time and walks it one beat
 * at a time: request, memory read, capture, then hold R until rready.
 */
`timescale 1ns/10ps
`default_nettype none

module axi_rd_engine (
  input  logic                            clk,
  input  logic                            i_reset,
  input  logic [defs_pkg::AXI_ID_W-1:0]   i_axi_arid,
  input  logic [defs_pkg::AXI_ADDR_W-1:0] i_axi_araddr,
  input  logic [defs_pkg::AXI_LEN_W-1:0]  i_axi_arlen,
  input  logic [1:0]                      i_axi_arburst,
  input  logic                            i_axi_arvalid,
  output logic                            o_axi_arready,
  output logic [defs_pkg::AXI_ID_W-1:0]   o_axi_rid,
  output logic [defs_pkg::DATA_W-1:0]     o_axi_rdata,
  output logic [1:0]                      o_axi_rresp,
  output logic                            o_axi_rlast,
  output logic                            o_axi_rvalid,
  input  logic                            i_axi_rready,
  ssram_if.engine                         o_mem,
  input  logic [defs_pkg::DATA_W-1:0]     i_mem_rdata
);
  import defs_pkg::*;

  rd_state_e            state;
  logic [AXI_ID_W-1:0]  r_id;
  logic [MEM_AW-1:0]    r_addr;
  logic [AXI_LEN_W-1:0] r_len;
  logic [AXI_LEN_W-1:0] r_cnt;
  logic                 r_incr;
  logic                 r_oor;
  logic [DATA_W-1:0]    r_data;
  logic                 ar_hs;
  logic                 r_beat;

  assign ar_hs  = o_axi_arready && i_axi_arvalid;
  assign r_beat = o_axi_rvalid && i_axi_rready;

  assign o_axi_arready = (state == R_IDLE);
  assign o_axi_rvalid  = (state == R_SEND);
  assign o_axi_rid     = r_id;
  assign o_axi_rdata   = r_data;
  assign o_axi_rresp   = r_oor ? RESP_SLVERR : RESP_OKAY;
  assign o_axi_rlast   = (state == R_SEND) && (r_cnt == r_len);

  // Read-only requester
  assign o_mem.req   = (state == R_ISSUE) && !r_oor;
  assign o_mem.we    = 1'b0;
  assign o_mem.addr  = r_addr;
  assign o_mem.wdata = '0;
  assign o_mem.be    = '0;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      state <= R_IDLE;
    end else begin
      case (state)
        R_IDLE: if (ar_hs) state <= R_ISSUE;
        R_ISSUE: begin
          if (r_oor) begin
            state <= R_SEND;
          end else if (o_mem.gnt) begin
            state <= R_WAIT;
          end
        end
        R_WAIT: state <= R_SEND;
        R_SEND: if (r_beat) state <= o_axi_rlast ? R_IDLE : R_ISSUE;
        default: state <= R_IDLE;
      endcase
    end
  end

  // Burst context, counters and the R holding register
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      r_id   <= i_axi_arid;
      r_addr <= i_axi_araddr[MEM_AW+WORD_LSB-1:WORD_LSB];
      r_len  <= i_axi_arlen;
      r_cnt  <= '0;
      r_incr <= (i_axi_arburst != BURST_FIXED);
      r_oor  <= |i_axi_araddr[AXI_ADDR_W-1:MEM_AW+WORD_LSB];
    end else if (state == R_ISSUE && r_oor) begin
      r_data <= '0;
    end else if (state == R_WAIT) begin
      r_data <= i_mem_rdata;
    end else if (r_beat) begin
      r_cnt <= r_cnt + 1'b1;
      if (r_incr) begin
        r_addr <= r_addr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- ssram_arbiter.sv
/*
 * Round-robin arbiter for the single SSRAM port. Grants one of the two
 * engines per cycle and steers its request onto the memory pins.
 */
`timescale 1ns/10ps
`default_nettype none

module ssram_arbiter (
  input  logic                        clk,
  input  logic                        i_reset,
  ssram_if.arbiter                    i_wr,
  ssram_if.arbiter                    i_rd,
  output logic                        o_en,
  output logic                        o_we,
  output logic [defs_pkg::MEM_AW-1:0] o_addr,
  output logic [defs_pkg::DATA_W-1:0] o_wdata,
  output logic [defs_pkg::STRB_W-1:0] o_be
);
  import defs_pkg::*;

  // Set when the write engine won the last grant
  logic last_wr;

  // On a tie the engine that lost last time wins
  assign i_wr.gnt = i_wr.req && (!i_rd.req || !last_wr);
  assign i_rd.gnt = i_rd.req && (!i_wr.req || last_wr);

  always_ff @(posedge clk) begin
    if (i_reset) begin
      last_wr <= 1'b0;
    end else if (i_wr.gnt) begin
      last_wr <= 1'b1;
    end else if (i_rd.gnt) begin
      last_wr <= 1'b0;
    end
  end

  always_comb begin
    o_en = i_wr.gnt || i_rd.gnt;
    if (i_wr.gnt) begin
      o_we    = i_wr.we;
      o_addr  = i_wr.addr;
      o_wdata = i_wr.wdata;
      o_be    = i_wr.be;
    end else begin
      o_we    = i_rd.gnt && i_rd.we;
      o_addr  = i_rd.addr;
      o_wdata = i_rd.wdata;
      o_be    = i_rd.be;
    end
  end

endmodule

`default_nettype wire

//--- ssram_model.sv
/*
 * Single-port synchronous SRAM, 1024 words of 64 bits, with byte enables.
 * Read data appears on the cycle after the enabled read.
 */
`timescale 1ns/10ps
`default_nettype none

module ssram_model (
  input  logic                        clk,
  input  logic                        i_en,
  input  logic                        i_we,
  input  logic [defs_pkg::MEM_AW-1:0] i_addr,
  input  logic [defs_pkg::DATA_W-1:0] i_wdata,
  input  logic [defs_pkg::STRB_W-1:0] i_be,
  output logic [defs_pkg::DATA_W-1:0] o_rdata
);
  import defs_pkg::*;

  logic [DATA_W-1:0] mem [MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (i_en) begin
      if (i_we) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (i_be[b]) begin
            mem[i_addr][8*b +: 8] <= i_wdata[8*b +: 8];
          end
        end
      end else begin
        // Output only changes on reads
        o_rdata <= mem[i_addr];
      end
    end
  end

endmodule

`default_nettype wire

//--- ssram_ctrl.sv
/*
 * AXI4 slave SSRAM controller, 1024 x 64 bit on-chip memory.
 * Write and read engines share one single-port SSRAM through an arbiter.
 */
`timescale 1ns/10ps
`default_nettype none

module ssram_ctrl (
  input  logic                            clk,
  input  logic                            i_reset,
  // AW
  input  logic [defs_pkg::AXI_ID_W-1:0]   i_axi_awid,
  input  logic [defs_pkg::AXI_ADDR_W-1:0] i_axi_awaddr,
  input  logic [defs_pkg::AXI_LEN_W-1:0]  i_axi_awlen,
  input  logic [1:0]                      i_axi_awburst,
  input  logic                            i_axi_awvalid,
  output logic                            o_axi_awready,
  // W
  input  logic [defs_pkg::DATA_W-1:0]     i_axi_wdata,
  input  logic [defs_pkg::STRB_W-1:0]     i_axi_wstrb,
  input  logic                            i_axi_wlast,
  input  logic                            i_axi_wvalid,
  output logic                            o_axi_wready,
  // B
  output logic [defs_pkg::AXI_ID_W-1:0]   o_axi_bid,
  output logic [1:0]                      o_axi_bresp,
  output logic                            o_axi_bvalid,
  input  logic                            i_axi_bready,
  // AR
  input  logic [defs_pkg::AXI_ID_W-1:0]   i_axi_arid,
  input  logic [defs_pkg::AXI_ADDR_W-1:0] i_axi_araddr,
  input  logic [defs_pkg::AXI_LEN_W-1:0]  i_axi_arlen,
  input  logic [1:0]                      i_axi_arburst,
  input  logic                            i_axi_arvalid,
  output logic                            o_axi_arready,
  // R
  output logic [defs_pkg::AXI_ID_W-1:0]   o_axi_rid,
  output logic [defs_pkg::DATA_W-1:0]     o_axi_rdata,
  output logic [1:0]                      o_axi_rresp,
  output logic                            o_axi_rlast,
  output logic                            o_axi_rvalid,
  input  logic                            i_axi_rready
);
  import defs_pkg::*;

  ssram_if wr_bus ();
  ssram_if rd_bus ();

  logic              mem_en;
  logic              mem_we;
  logic [MEM_AW-1:0] mem_addr;
  logic [DATA_W-1:0] mem_wdata;
  logic [STRB_W-1:0] mem_be;
  logic [DATA_W-1:0] mem_rdata;

  axi_wr_engine wr_engine_inst (
    .clk,
    .i_reset,
    .i_axi_awid,
    .i_axi_awaddr,
    .i_axi_awlen,
    .i_axi_awburst,
    .i_axi_awvalid,
    .o_axi_awready,
    .i_axi_wdata,
    .i_axi_wstrb,
    .i_axi_wlast,
    .i_axi_wvalid,
    .o_axi_wready,
    .o_axi_bid,
    .o_axi_bresp,
    .o_axi_bvalid,
    .i_axi_bready,
    .o_mem (wr_bus.engine)
  );

  axi_rd_engine rd_engine_inst (
    .clk,
    .i_reset,
    .i_axi_arid,
    .i_axi_araddr,
    .i_axi_arlen,
    .i_axi_arburst,
    .i_axi_arvalid,
    .o_axi_arready,
    .o_axi_rid,
    .o_axi_rdata,
    .o_axi_rresp,
    .o_axi_rlast,
    .o_axi_rvalid,
    .i_axi_rready,
    .o_mem       (rd_bus.engine),
    .i_mem_rdata (mem_rdata)
  );

  ssram_arbiter arbiter_inst (
    .clk,
    .i_reset,
    .i_wr    (wr_bus.arbiter),
    .i_rd    (rd_bus.arbiter),
    .o_en    (mem_en),
    .o_we    (mem_we),
    .o_addr  (mem_addr),
    .o_wdata (mem_wdata),
    .o_be    (mem_be)
  );

  ssram_model ssram_inst (
    .clk,
    .i_en    (mem_en),
    .i_we    (mem_we),
    .i_addr  (mem_addr),
    .i_wdata (mem_wdata),
    .i_be    (mem_be),
    .o_rdata (mem_rdata)
  );

endmodule

`default_nettype wire

//--- ssram_checker.sv
/*
 * Concurrent AXI protocol and arbitration checks for the SSRAM controller.
 * Attached to the controller top level with bind.
 */
`timescale 1ns/10ps
`default_nettype none

module ssram_checker (
  input logic                            clk,
  input logic                            i_reset,
  input logic                            i_wr_gnt,
  input logic                            i_rd_gnt,
  input logic                            i_awvalid,
  input logic                            i_awready,
  input logic                            i_wvalid,
  input logic                            i_wready,
  input logic                            i_wlast,
  input logic [defs_pkg::AXI_ID_W-1:0]   i_bid,
  input logic [1:0]                      i_bresp,
  input logic                            i_bvalid,
  input logic                            i_bready,
  input logic [defs_pkg::AXI_ID_W-1:0]   i_rid,
  input logic [defs_pkg::DATA_W-1:0]     i_rdata,
  input logic [1:0]                      i_rresp,
  input logic                            i_rlast,
  input logic                            i_rvalid,
  input logic                            i_rready
);

  int   fail_count = 0;
  logic in_burst;

  // Write burst window, AW handshake up to the wlast beat
  always_ff @(posedge clk) begin
    if (i_reset) begin
      in_burst <= 1'b0;
    end else if (i_awvalid && i_awready) begin
      in_burst <= 1'b1;
    end else if (i_wvalid && i_wready && i_wlast) begin
      in_burst <= 1'b0;
    end
  end

  b_hold: assert property (@(posedge clk) disable iff (i_reset)
    i_bvalid && !i_bready |=> i_bvalid && $stable(i_bid) && $stable(i_bresp))
    else begin
      $error("B channel changed before bready");
      fail_count++;
    end

  r_hold: assert property (@(posedge clk) disable iff (i_reset)
    i_rvalid && !i_rready |=> i_rvalid && $stable(i_rid) && $stable(i_rdata)
      && $stable(i_rresp) && $stable(i_rlast))
    else begin
      $error("R channel changed before rready");
      fail_count++;
    end

  gnt_excl: assert property (@(posedge clk) disable iff (i_reset)
    !(i_wr_gnt && i_rd_gnt))
    else begin
      $error("Both engines granted the memory port");
      fail_count++;
    end

  rlast_valid: assert property (@(posedge clk) disable iff (i_reset)
    i_rlast |-> i_rvalid)
    else begin
      $error("rlast high without rvalid");
      fail_count++;
    end

  wready_burst: assert property (@(posedge clk) disable iff (i_reset)
    !in_burst |-> !i_wready)
    else begin
      $error("wready high outside a write burst");
      fail_count++;
    end

endmodule

bind ssram_ctrl ssram_checker checker_inst (
  .clk,
  .i_reset,
  .i_wr_gnt  (wr_bus.gnt),
  .i_rd_gnt  (rd_bus.gnt),
  .i_awvalid (i_axi_awvalid),
  .i_awready (o_axi_awready),
  .i_wvalid  (i_axi_wvalid),
  .i_wready  (o_axi_wready),
  .i_wlast   (i_axi_wlast),
  .i_bid     (o_axi_bid),
  .i_bresp   (o_axi_bresp),
  .i_bvalid  (o_axi_bvalid),
  .i_bready  (i_axi_bready),
  .i_rid     (o_axi_rid),
  .i_rdata   (o_axi_rdata),
  .i_rresp   (o_axi_rresp),
  .i_rlast   (o_axi_rlast),
  .i_rvalid  (o_axi_rvalid),
  .i_rready  (i_axi_rready)
);

`default_nettype wire

//--- tb_ssram_ctrl.sv
/*
 * Testbench for the AXI4 SSRAM controller. Runs directed and random bursts
 * against a shadow memory and checks every B response and R beat.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_ssram_ctrl;
  import defs_pkg::*;

  localparam logic [31:0] SEED    = 32'h937e2a0f;
  localparam logic [31:0] OOR_BIT = 32'h0010_0000;

  logic                  clk = 1'b0;
  logic                  i_reset;
  logic [AXI_ID_W-1:0]   i_axi_awid;
  logic [AXI_ADDR_W-1:0] i_axi_awaddr;
  logic [AXI_LEN_W-1:0]  i_axi_awlen;
  logic [1:0]            i_axi_awburst;
  logic                  i_axi_awvalid;
  logic                  o_axi_awready;
  logic [DATA_W-1:0]     i_axi_wdata;
  logic [STRB_W-1:0]     i_axi_wstrb;
  logic                  i_axi_wlast;
  logic                  i_axi_wvalid;
  logic                  o_axi_wready;
  logic [AXI_ID_W-1:0]   o_axi_bid;
  logic [1:0]            o_axi_bresp;
  logic                  o_axi_bvalid;
  logic                  i_axi_bready;
  logic [AXI_ID_W-1:0]   i_axi_arid;
  logic [AXI_ADDR_W-1:0] i_axi_araddr;
  logic [AXI_LEN_W-1:0]  i_axi_arlen;
  logic [1:0]            i_axi_arburst;
  logic                  i_axi_arvalid;
  logic                  o_axi_arready;
  logic [AXI_ID_W-1:0]   o_axi_rid;
  logic [DATA_W-1:0]     o_axi_rdata;
  logic [1:0]            o_axi_rresp;
  logic                  o_axi_rlast;
  logic                  o_axi_rvalid;
  logic                  i_axi_rready;

  logic [DATA_W-1:0] shadow [MEM_DEPTH];
  int                checks = 0;
  int                data_errors = 0;
  int                ctrl_errors = 0;
  int                planned_beats = 0;
  bit                rand_ready = 1'b0;

  ssram_ctrl ssram_ctrl_inst (.*);

  always #10 clk = ~clk;

  // New bytes where the strobe is set, old bytes elsewhere
  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
      input logic [DATA_W-1:0] new_word, input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] result;
    result = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) result[8*b +: 8] = new_word[8*b +: 8];
    end
    return result;
  endfunction

  task automatic check_field(input string name, input logic [DATA_W-1:0] got,
      input logic [DATA_W-1:0] exp, input bit is_ctrl);
    checks++;
    assert (got === exp) else begin
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
      if (is_ctrl) ctrl_errors++;
      else data_errors++;
    end
  endtask

  // Called right after a falling edge, returns right after one
  task automatic write_burst(input logic [AXI_ID_W-1:0] id, input logic [31:0] addr,
      input int len, input logic [1:0] burst, input bit full_strb);
    logic [MEM_AW-1:0] word;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    bit                oor;
    bit                done;
    word = MEM_AW'(addr / STRB_W);
    oor = (addr >= 32'(MEM_DEPTH * STRB_W));
    i_axi_awid = id;
    i_axi_awaddr = addr;
    i_axi_awlen = 8'(len - 1);
    i_axi_awburst = burst;
    i_axi_awvalid = 1'b1;
    #1;
    while (!o_axi_awready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    i_axi_awvalid = 1'b0;
    for (int b = 0; b < len; b++) begin
      data = {$urandom, $urandom};
      strb = full_strb ? '1 : STRB_W'($urandom);
      i_axi_wdata = data;
      i_axi_wstrb = strb;
      i_axi_wlast = (b == len - 1);
      i_axi_wvalid = 1'b1;
      #1;
      while (!o_axi_wready) begin
        @(negedge clk);
        #1;
      end
      if (!oor) shadow[word] = merge_bytes(shadow[word], data, strb);
      if (burst == BURST_INCR) word++;
      @(negedge clk);
    end
    i_axi_wvalid = 1'b0;
    i_axi_wlast = 1'b0;
    done = 1'b0;
    while (!done) begin
      i_axi_bready = rand_ready ? 1'($urandom) : 1'b1;
      #1;
      if (o_axi_bvalid && i_axi_bready) begin
        check_field("bid", 64'(o_axi_bid), 64'(id), 1'b1);
        check_field("bresp", 64'(o_axi_bresp), 64'(oor ? RESP_SLVERR : RESP_OKAY), 1'b1);
        done = 1'b1;
      end
      @(negedge clk);
    end
    i_axi_bready = 1'b0;
  endtask

  task automatic read_burst(input logic [AXI_ID_W-1:0] id, input logic [31:0] addr,
      input int len, input logic [1:0] burst);
    logic [MEM_AW-1:0] word;
    logic [DATA_W-1:0] expect_data;
    bit                oor;
    int                beat;
    word = MEM_AW'(addr / STRB_W);
    oor = (addr >= 32'(MEM_DEPTH * STRB_W));
    i_axi_arid = id;
    i_axi_araddr = addr;
    i_axi_arlen = 8'(len - 1);
    i_axi_arburst = burst;
    i_axi_arvalid = 1'b1;
    #1;
    while (!o_axi_arready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    i_axi_arvalid = 1'b0;
    beat = 0;
    while (beat < len) begin
      i_axi_rready = rand_ready ? 1'($urandom) : 1'b1;
      #1;
      if (o_axi_rvalid && i_axi_rready) begin
        expect_data = oor ? '0 : shadow[word];
        check_field("rdata", o_axi_rdata, expect_data, 1'b0);
        check_field("rid", 64'(o_axi_rid), 64'(id), 1'b1);
        check_field("rresp", 64'(o_axi_rresp), 64'(oor ? RESP_SLVERR : RESP_OKAY), 1'b1);
        check_field("rlast", 64'(o_axi_rlast), 64'(beat == len - 1), 1'b1);
        if (burst == BURST_INCR) word++;
        beat++;
      end
      @(negedge clk);
    end
    i_axi_rready = 1'b0;
  endtask

  initial begin
    int incr_len [4];
    int fixed_len;
    int conc_len;
    void'($urandom(SEED));
    foreach (incr_len[i]) incr_len[i] = $urandom_range(16, 1);
    fixed_len = $urandom_range(8, 2);
    conc_len = $urandom_range(16, 4);
    i_reset = 1'b1;
    i_axi_awid = '0;
    i_axi_awaddr = '0;
    i_axi_awlen = '0;
    i_axi_awburst = BURST_INCR;
    i_axi_awvalid = 1'b0;
    i_axi_wdata = '0;
    i_axi_wstrb = '0;
    i_axi_wlast = 1'b0;
    i_axi_wvalid = 1'b0;
    i_axi_bready = 1'b0;
    i_axi_arid = '0;
    i_axi_araddr = '0;
    i_axi_arlen = '0;
    i_axi_arburst = BURST_INCR;
    i_axi_arvalid = 1'b0;
    i_axi_rready = 1'b0;
    // Total beats of all tests below set the watchdog limit
    planned_beats = 2 + 12 + fixed_len + 4 + 5 * conc_len + 6;
    foreach (incr_len[i]) planned_beats += 2 * incr_len[i];
    repeat (10) @(posedge clk);
    @(negedge clk);
    i_reset = 1'b0;

    write_burst(2'd1, 32'h28, 1, BURST_INCR, 1'b1);
    read_burst(2'd2, 32'h28, 1, BURST_INCR);
    foreach (incr_len[i]) begin
      write_burst(2'(i), 32'((64 + 16 * i) * 8), incr_len[i], BURST_INCR, 1'b1);
      read_burst(2'(i + 1), 32'((64 + 16 * i) * 8), incr_len[i], BURST_INCR);
    end
    repeat (4) begin
      write_burst(2'd0, 32'(200 * 8), 1, BURST_INCR, 1'b1);
      write_burst(2'd1, 32'(200 * 8), 1, BURST_INCR, 1'b0);
      read_burst(2'd2, 32'(200 * 8), 1, BURST_INCR);
    end
    write_burst(2'd3, 32'(300 * 8), fixed_len, BURST_FIXED, 1'b1);
    read_burst(2'd0, 32'(300 * 8), 4, BURST_FIXED);

    // Writes and reads on disjoint regions in parallel
    write_burst(2'd1, 32'(600 * 8), conc_len, BURST_INCR, 1'b1);
    rand_ready = 1'b1;
    repeat (2) begin
      fork
        write_burst(2'd2, 32'(700 * 8), conc_len, BURST_INCR, 1'b1);
        read_burst(2'd3, 32'(600 * 8), conc_len, BURST_INCR);
      join
    end
    rand_ready = 1'b0;

    write_burst(2'd3, OOR_BIT | 32'h28, 2, BURST_INCR, 1'b1);
    read_burst(2'd1, OOR_BIT | 32'h28, 3, BURST_INCR);
    read_burst(2'd0, 32'h28, 1, BURST_INCR);

    $display("Checks %0d, data errors %0d, control errors %0d, assertion failures %0d",
      checks, data_errors, ctrl_errors, ssram_ctrl_inst.checker_inst.fail_count);
    if (data_errors + ctrl_errors + ssram_ctrl_inst.checker_inst.fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog allows 200 cycles per planned beat
  initial begin
    wait (planned_beats > 0);
    repeat (200 * planned_beats) @(posedge clk);
    $display("Timeout: bursts still running after %0d cycles", 200 * planned_beats);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
defs_pkg.sv
ssram_if.sv
axi_wr_engine.sv
axi_rd_engine.sv
ssram_arbiter.sv
ssram_model.sv
ssram_ctrl.sv
ssram_checker.sv
tb_ssram_ctrl.sv

//--- Makefile
# Verilator simulation of the AXI4 SSRAM controller

VERILATOR ?= verilator
TOP       ?= tb_ssram_ctrl
FILELIST  ?= sim.f
LOG       ?= sim.log
RUNFLAGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF '*** FAILED ***' $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf obj_dir $(LOG)
